/* project.f */
pcm_decoder_pkg.sv
decoder_regs.sv
biphase_to_nrz.sv
mark_space_decode.sv
nrz_derandomizer.sv
pcm_decoder.sv
pcm_decoder_properties.sv
tb_pcm_decoder.sv

/* run.sh */
#!/bin/sh
# Compile and run the PCM decoder testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wall -Wno-fatal \
  --top-module tb_pcm_decoder -f project.f

# A nonzero exit from the model is itself a failure
./obj_dir/Vtb_pcm_decoder > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q ">>> FAIL" sim.log; then
  exit 1
fi
exit 0

/* tb_pcm_decoder.sv */
//----------------------------------------
// PCM bit decoder testbench
// Random source bits, line encoding, stream compare
//----------------------------------------

`timescale 1ns/100ps

module tb_pcm_decoder;

  import pcm_decoder_pkg::*;

  localparam int NBITS = 64;
  localparam int WARM  = DERAND_LEN + 4;
  localparam int MAX_OFS = 8;

  logic         clk, rs, symb_en_i, symb_2x_en_i, bit_en_o, data_clk_o, gen_on, collect;
  reg_bus_req_t bus_i;
  symb_pair_t   symb_i, data_o;
  reg_data_t    rdata_o, rd;
  logic [2:0]   ph_cnt;
  logic         src_i [NBITS];
  logic         src_q [NBITS];
  symb_pair_t   tx_q[$];
  symb_pair_t   rx_q[$];
  integer       seed = 32'hf4f4b39e;
  int           checks, errors, timeouts;
  logic         clk_sel_exp;
  int           clk_hi, clk_lo;

  pcm_decoder UUT (.*);

  bind pcm_decoder pcm_decoder_properties u_props (
    .clk (clk), .rs (rs), .bus_wr (bus_i.wr), .symb_en_i (symb_en_i),
    .symb_2x_en_i (symb_2x_en_i), .bit_en_o (bit_en_o), .data_clk_o (data_clk_o),
    .data_o (data_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //----------------------------------------
  // Strobes and symbol feed
  //----------------------------------------

  // Symbol every 8 cycles and half symbol every 4
  always @(posedge clk) begin
    if (rs || !gen_on) begin
      ph_cnt       <= '0;
      symb_en_i    <= 1'b0;
      symb_2x_en_i <= 1'b0;
    end else begin
      ph_cnt       <= ph_cnt + 1'b1;
      symb_en_i    <= (ph_cnt == 3'd0);
      symb_2x_en_i <= (ph_cnt[1:0] == 2'd0);
      if (ph_cnt == 3'd0) begin
        // Random filler when no test symbols wait
        if (tx_q.size() > 0) symb_i <= tx_q.pop_front();
        else symb_i <= symb_pair_t'($random(seed));
      end
    end
  end

  // Output bits and data clock taken mid cycle
  always @(negedge clk) begin
    if (collect) begin
      if (bit_en_o) rx_q.push_back(data_o);
      if (clk_sel_exp) begin
        if (data_clk_o) clk_hi++;
        else clk_lo++;
      end else begin
        // Without clk_sel the data clock is the raw bit strobe
        check_value("data_clk", rx_q.size(), bit_en_o, data_clk_o);
      end
    end
  end

  //----------------------------------------
  // Reference model
  //----------------------------------------

  // Scramble then line-encode one bit and update encoder state
  function automatic logic encode_bit(input logic b, input dec_cfg_t c,
                                      inout logic prev, inout logic [14:0] hist);
    logic s;
    logic t;
    s = b;
    if (c.derand_mode == DERAND_RNRZ15) s = b ^ hist[14] ^ hist[13];
    if (c.derand_mode == DERAND_RNRZ11) s = b ^ hist[10] ^ hist[8];
    hist = {hist[13:0], s};
    t = s;
    // Mark flips on one and space flips on zero
    if (c.code_mode == NRZ_M) t = s ^ prev;
    if (c.code_mode == NRZ_S) t = ~s ^ prev;
    prev = t;
    return t;
  endfunction

  // Expected pair for output bit k
  function automatic symb_pair_t predict_bit(input int k, input dec_cfg_t c);
    symb_pair_t p;
    logic       b;
    if (c.demux_en) begin
      b = ((k % 2 == 0) ^ c.iq_swap) ? src_i[k/2] : src_q[k/2];
      p = {b, b};
    end else if (c.iq_swap) p = {src_q[k], src_i[k]};
    else p = {src_i[k], src_q[k]};
    // Derandomized I output drives both rails
    if (c.derand_mode != DERAND_OFF) p.q = p.i;
    return p ^ {2{c.data_inv}};
  endfunction

  //----------------------------------------
  // Bus and check helpers
  //----------------------------------------

  task automatic check_value(input string name, input int idx, input reg_data_t exp,
                             input reg_data_t act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("ERROR %s [%0d]: expected %h, actual %h", name, idx, exp, act);
    end
  endtask

  task automatic bus_write(input reg_addr_t a, input reg_data_t d);
    @(posedge clk);
    bus_i <= {1'b1, a, d};
    @(posedge clk);
    bus_i.wr <= 1'b0;
  endtask

  task automatic bus_read(input reg_addr_t a, output reg_data_t d);
    @(posedge clk);
    bus_i <= {1'b0, a, 32'h0};
    @(negedge clk);
    d = rdata_o;
  endtask

  // Returns just after a symbol strobe
  task automatic wait_strobe();
    int t;
    t = 0;
    do begin
      @(negedge clk);
      t++;
    end while (!symb_en_i && t < 20);
    if (!symb_en_i) begin
      timeouts++;
      $display("Timeout: no symbol strobe seen");
    end
  endtask

  task automatic test_regs();
    int n;
    int t;
    wait_strobe();
    bus_write(ADDR_CONTROL, 32'hABCD_E1F5);
    bus_read(ADDR_STATUS, rd);
    check_value("status_clear", 0, 32'h0000_01F5, rd);
    // Count runs from the cycle of the clearing read
    n = 0;
    t = 0;
    if (bit_en_o) n++;
    while (n < 5 && t < 200) begin
      @(negedge clk);
      if (bit_en_o) n++;
      t++;
    end
    if (n < 5) begin
      timeouts++;
      $display("Timeout: status test saw too few bit strobes");
    end
    bus_read(ADDR_STATUS, rd);
    check_value("status_count", n, {16'(n), 16'h01F5}, rd);
    bus_read(ADDR_CONTROL, rd);
    check_value("control", 0, 32'h0000_01F5, rd);
    bus_read(4'h7, rd);
    check_value("unmapped", 7, 32'h0, rd);
  endtask

  // Send source through the encoder then align and compare the stream
  task automatic run_stream(input string name, input dec_cfg_t c);
    logic [14:0] hi, hq;
    logic        pi, pq, ti, tq;
    int          m, t, best, best_err, e;
    symb_pair_t  ex;
    hi = '0;
    hq = '0;
    pi = 1'b0;
    pq = 1'b0;
    for (int k = 0; k < NBITS; k++) begin
      src_i[k] = $random(seed);
      src_q[k] = $random(seed);
    end
    wait_strobe();
    bus_write(ADDR_CONTROL, reg_data_t'(c));
    tx_q.delete();
    rx_q.delete();
    for (int k = 0; k < NBITS; k++) begin
      ti = encode_bit(src_i[k], c, pi, hi);
      tq = encode_bit(src_q[k], c, pq, hq);
      tx_q.push_back({ti, tq});
      // Biphase sends the bit then its inverse
      if (c.biphase_en) tx_q.push_back({~ti, ~tq});
    end
    clk_sel_exp = c.clk_sel;
    clk_hi = 0;
    clk_lo = 0;
    collect = 1'b1;
    m = c.demux_en ? 2 * NBITS : NBITS;
    t = 0;
    while (rx_q.size() < m + MAX_OFS && t < (m + MAX_OFS) * 20) begin
      @(negedge clk);
      t++;
    end
    collect = 1'b0;
    // Square wave spends as long high as low
    if (c.clk_sel) begin
      checks++;
      assert (clk_hi <= clk_lo + 16 && clk_lo <= clk_hi + 16) else begin
        errors++;
        $display("ERROR %s data_clk_high: expected %0d, actual %0d", name, clk_lo, clk_hi);
      end
    end
    if (rx_q.size() < m + MAX_OFS) begin
      timeouts++;
      $display("Timeout: %s collected too few output bits", name);
      return;
    end
    best = 0;
    best_err = m;
    for (int o = 0; o <= MAX_OFS; o++) begin
      e = 0;
      for (int j = WARM; j < m; j++) begin
        ex = predict_bit(j, c);
        // Only I is compared in biphase since Q is not biphase decoded
        if (c.biphase_en) e += (rx_q[o+j].i !== ex.i);
        else e += (rx_q[o+j] !== ex);
      end
      if (e < best_err) begin
        best_err = e;
        best = o;
      end
    end
    for (int j = WARM; j < m; j++) begin
      ex = predict_bit(j, c);
      if (c.biphase_en) check_value(name, j, ex.i, rx_q[best+j].i);
      else check_value(name, j, ex, rx_q[best+j]);
    end
  endtask

  function automatic dec_cfg_t make_cfg(input code_mode_e cm, input derand_mode_e dm,
                                        input logic bip, input logic dmx, input logic sw,
                                        input logic inv);
    dec_cfg_t c;
    c = '0;
    c.code_mode   = cm;
    c.derand_mode = dm;
    c.biphase_en  = bip;
    c.demux_en    = dmx;
    c.iq_swap     = sw;
    c.data_inv    = inv;
    c.clk_sel     = sw;
    return c;
  endfunction

  //----------------------------------------
  // Main sequence
  //----------------------------------------

  initial begin
    rs = 1'b1;
    bus_i = '0;
    symb_en_i = 1'b0;
    symb_2x_en_i = 1'b0;
    symb_i = '0;
    gen_on = 1'b0;
    collect = 1'b0;
    clk_sel_exp = 1'b0;
    clk_hi = 0;
    clk_lo = 0;
    checks = 0;
    errors = 0;
    timeouts = 0;
    repeat (10) @(posedge clk);
    rs <= 1'b0;
    repeat (2) @(posedge clk);
    gen_on <= 1'b1;
    test_regs();
    run_stream("nrz_l", make_cfg(NRZ_L, DERAND_OFF, 0, 0, 0, 0));
    run_stream("nrz_l_swap_inv", make_cfg(NRZ_L, DERAND_OFF, 0, 0, 1, 1));
    run_stream("nrz_m", make_cfg(NRZ_M, DERAND_OFF, 0, 0, 0, 0));
    run_stream("nrz_s", make_cfg(NRZ_S, DERAND_OFF, 0, 0, 0, 0));
    run_stream("biphase", make_cfg(NRZ_L, DERAND_OFF, 1, 0, 0, 0));
    run_stream("rnrz15", make_cfg(NRZ_L, DERAND_RNRZ15, 0, 0, 0, 0));
    run_stream("rnrz11", make_cfg(NRZ_L, DERAND_RNRZ11, 0, 0, 0, 1));
    run_stream("demux", make_cfg(NRZ_L, DERAND_OFF, 0, 1, 0, 0));
    run_stream("demux_swap", make_cfg(NRZ_L, DERAND_OFF, 0, 1, 1, 0));
    $display("Checks: %0d  Errors: %0d  Timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* pcm_decoder_properties.sv */
//----------------------------------------
// PCM decoder strobe and reset checks
//----------------------------------------

`timescale 1ns/100ps

module pcm_decoder_properties (
  input logic                        clk,
  input logic                        rs,
  input logic                        bus_wr,
  input logic                        symb_en_i,
  input logic                        symb_2x_en_i,
  input logic                        bit_en_o,
  input logic                        data_clk_o,
  input pcm_decoder_pkg::symb_pair_t data_o
);

  logic any_strobe;

  assign any_strobe = symb_en_i | symb_2x_en_i;

  // Quiet through reset and one cycle beyond
  a_reset_quiet: assert property (@(posedge clk) (rs || $past(rs)) |-> !bit_en_o)
    else $error("bit strobe active during or right after reset");

  // Output bits move only on the edge that ends a bit strobe or a config write
  a_strobe_src: assert property (@(posedge clk) disable iff (rs)
    (!$past(bit_en_o) && !$past(bus_wr) && !$past(rs)) |-> $stable(data_o))
    else $error("output bits changed without a bit strobe");

  // Data clock holds with no strobe and no config change
  a_clk_hold: assert property (@(posedge clk) disable iff (rs)
    (!any_strobe && !$past(any_strobe) && !$past(bus_wr) && !$past(rs)) |->
    $stable(data_clk_o))
    else $error("data clock moved without a strobe");

endmodule

/* pcm_decoder.sv */
//----------------------------------------
// PCM bit decoder top level
// Symbol decisions in, decoded bits, bit strobe and data clock out
//----------------------------------------

`timescale 1ns/100ps

module pcm_decoder (
  input  logic                          clk,
  input  logic                          rs,
  input  pcm_decoder_pkg::reg_bus_req_t bus_i,
  input  logic                          symb_en_i,
  input  logic                          symb_2x_en_i,
  input  pcm_decoder_pkg::symb_pair_t   symb_i,
  output pcm_decoder_pkg::symb_pair_t   data_o,
  output logic                          bit_en_o,
  output logic                          data_clk_o,
  output pcm_decoder_pkg::reg_data_t    rdata_o
);

  import pcm_decoder_pkg::*;

  dec_cfg_t cfg;
  logic     cfg_load;
  logic     nrz_i, nrz_q;
  logic     half_en, sym_en;
  logic     dec_i, dec_q;
  logic     mux_first, demux_bit;
  logic     out_en, mid_en;
  logic     sel_i, sel_q;
  logic     derand_bit;
  logic     rail_i, rail_q;
  logic     clk_q;

  decoder_regs u_regs (
    .clk        (clk),
    .rs         (rs),
    .bus_i      (bus_i),
    .cfg_o      (cfg),
    .cfg_load_o (cfg_load),
    .bit_en_i   (out_en),
    .rdata_o    (rdata_o)
  );

  //----------------------------------------
  // Biphase and rail alignment
  //----------------------------------------

  biphase_to_nrz u_biphase (
    .clk          (clk),
    .rs           (rs),
    .symb_en_i    (symb_en_i),
    .phase_clr_i  (cfg_load),
    .biphase_en_i (cfg.biphase_en),
    .symb_i       (symb_i.i),
    .nrz_o        (nrz_i),
    .half_en_o    (half_en)
  );

  // Qualified strobe, one per decoded bit
  assign sym_en = symb_en_i & half_en;

  // Q matches the one-strobe delay of the I path
  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      nrz_q <= 1'b0;
    end else if (sym_en) begin
      nrz_q <= symb_i.q;
    end
  end

  // Mark/space decode, same enable on both rails
  mark_space_decode u_msd_i (
    .clk (clk), .rs (rs), .en_i (sym_en), .mode_i (cfg.code_mode),
    .din_i (nrz_i), .dout_o (dec_i)
  );

  mark_space_decode u_msd_q (
    .clk (clk), .rs (rs), .en_i (sym_en), .mode_i (cfg.code_mode),
    .din_i (nrz_q), .dout_o (dec_q)
  );

  //----------------------------------------
  // Demux and output selection
  //----------------------------------------

  // High in the half symbol following a symbol strobe
  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      mux_first <= 1'b0;
    end else if (symb_2x_en_i) begin
      mux_first <= symb_en_i;
    end
  end

  // First half takes I (Q when swapped), second half the other rail
  assign demux_bit = (mux_first ^ cfg.iq_swap) ? dec_i : dec_q;

  assign out_en = cfg.demux_en ? symb_2x_en_i : sym_en;

  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      sel_i <= 1'b0;
      sel_q <= 1'b0;
    end else if (out_en) begin
      if (cfg.demux_en) begin
        sel_i <= demux_bit;
        sel_q <= demux_bit;
      end else if (cfg.iq_swap) begin
        sel_i <= dec_q;
        sel_q <= dec_i;
      end else begin
        sel_i <= dec_i;
        sel_q <= dec_q;
      end
    end
  end

  // Descrambles the I output, result drives both rails
  nrz_derandomizer u_derand (
    .clk (clk), .rs (rs), .en_i (out_en), .mode_i (cfg.derand_mode),
    .din_i (sel_i), .dout_o (derand_bit)
  );

  assign rail_i   = (cfg.derand_mode != DERAND_OFF) ? derand_bit : sel_i;
  assign rail_q   = (cfg.derand_mode != DERAND_OFF) ? derand_bit : sel_q;
  assign data_o.i = rail_i ^ cfg.data_inv;
  assign data_o.q = rail_q ^ cfg.data_inv;
  assign bit_en_o = out_en;

  //----------------------------------------
  // Data clock
  //----------------------------------------

  // Falling point halfway through a bit
  assign mid_en = cfg.biphase_en ? (symb_en_i & ~half_en) : (symb_2x_en_i & ~symb_en_i);

  // Demux bits come every half symbol, so the clock toggles per bit there
  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      clk_q <= 1'b0;
    end else if (cfg.demux_en) begin
      if (symb_2x_en_i) begin
        clk_q <= ~clk_q;
      end
    end else if (out_en) begin
      clk_q <= 1'b1;
    end else if (mid_en) begin
      clk_q <= 1'b0;
    end
  end

  assign data_clk_o = cfg.clk_sel ? clk_q : out_en;

endmodule

/* nrz_derandomizer.sv */
//----------------------------------------
// Self-synchronizing RNRZ descrambler
// RNRZ-15 or RNRZ-11, selectable
//----------------------------------------

`timescale 1ns/100ps

module nrz_derandomizer (
  input  logic                          clk,
  input  logic                          rs,
  input  logic                          en_i,
  input  pcm_decoder_pkg::derand_mode_e mode_i,
  input  logic                          din_i,
  output logic                          dout_o
);

  import pcm_decoder_pkg::*;

  // Received bit history, bit 0 is stage 1
  logic [DERAND_LEN-1:0] hist;
  logic                  fb;

  //----------------------------------------
  // Tap selection
  //----------------------------------------

  always_comb begin
    case (mode_i)
      DERAND_RNRZ15: fb = hist[RNRZ15_TAP_A-1] ^ hist[RNRZ15_TAP_B-1];
      DERAND_RNRZ11: fb = hist[RNRZ11_TAP_A-1] ^ hist[RNRZ11_TAP_B-1];
      // Off, straight through
      default:       fb = 1'b0;
    endcase
  end

  //----------------------------------------
  // Shift and descramble
  //----------------------------------------

  // History holds received bits, so it locks after DERAND_LEN bits
  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      hist   <= '0;
      dout_o <= 1'b0;
    end else if (en_i) begin
      hist   <= {hist[DERAND_LEN-2:0], din_i};
      dout_o <= din_i ^ fb;
    end
  end

endmodule

/* mark_space_decode.sv */
//----------------------------------------
// NRZ-L / NRZ-M / NRZ-S decoder, one rail
//----------------------------------------

`timescale 1ns/100ps

module mark_space_decode (
  input  logic                        clk,
  input  logic                        rs,
  input  logic                        en_i,
  input  pcm_decoder_pkg::code_mode_e mode_i,
  input  logic                        din_i,
  output logic                        dout_o
);

  import pcm_decoder_pkg::*;

  // Last received level
  logic prev;

  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      prev   <= 1'b0;
      dout_o <= 1'b0;
    end else if (en_i) begin
      prev <= din_i;
      case (mode_i)
        NRZ_L: dout_o <= din_i;
        // Mark, a transition means one
        NRZ_M: dout_o <= din_i ^ prev;
        // Space, a transition means zero
        NRZ_S: dout_o <= ~(din_i ^ prev);
        default: dout_o <= din_i;
      endcase
    end
  end

endmodule

/* biphase_to_nrz.sv */
//----------------------------------------
// Biphase to NRZ conversion, I rail
// Pairs half-symbols into bits, gives the bit phase strobe
//----------------------------------------

`timescale 1ns/100ps

module biphase_to_nrz (
  input  logic clk,
  input  logic rs,
  input  logic symb_en_i,
  input  logic phase_clr_i,
  input  logic biphase_en_i,
  input  logic symb_i,
  output logic nrz_o,
  output logic half_en_o
);

  // High after the first half-symbol of a bit
  logic phase;
  // High once a whole bit sits on nrz_o
  logic bit_rdy;
  logic first_half;

  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      phase   <= 1'b0;
      bit_rdy <= 1'b0;
      nrz_o   <= 1'b0;
    end else if (phase_clr_i) begin
      // Restart pairing on a config load
      phase   <= 1'b0;
      bit_rdy <= 1'b0;
    end else if (symb_en_i) begin
      if (!biphase_en_i) begin
        // NRZ input, one strobe of delay
        nrz_o   <= symb_i;
        phase   <= 1'b0;
        bit_rdy <= 1'b0;
      end else if (!phase) begin
        phase   <= 1'b1;
        bit_rdy <= 1'b0;
      end else begin
        // Second half, bit value is the first half
        nrz_o   <= first_half;
        phase   <= 1'b0;
        bit_rdy <= 1'b1;
      end
    end
  end

  // First half-symbol holding register
  always_ff @(posedge clk) begin
    if (symb_en_i && biphase_en_i && !phase) begin
      first_half <= symb_i;
    end
  end

  // Every strobe is a bit in NRZ mode
  assign half_en_o = ~biphase_en_i | bit_rdy;

endmodule

/* decoder_regs.sv */
//----------------------------------------
// Decoder control and status registers
// Holds the mode word, counts bit strobes for status read-back
//----------------------------------------

`timescale 1ns/100ps

module decoder_regs (
  input  logic                          clk,
  input  logic                          rs,
  input  pcm_decoder_pkg::reg_bus_req_t bus_i,
  output pcm_decoder_pkg::dec_cfg_t     cfg_o,
  output logic                          cfg_load_o,
  input  logic                          bit_en_i,
  output pcm_decoder_pkg::reg_data_t    rdata_o
);

  import pcm_decoder_pkg::*;

  logic      ctrl_wr;
  stat_cnt_t bit_cnt;

  // Only the control word is writable
  assign ctrl_wr = bus_i.wr && (bus_i.addr == ADDR_CONTROL);

  //----------------------------------------
  // Control word
  //----------------------------------------

  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      cfg_o      <= '0;
      cfg_load_o <= 1'b0;
    end else begin
      // Load pulse lines up with the new config
      cfg_load_o <= ctrl_wr;
      if (ctrl_wr) begin
        // Upper bits are reserved and dropped
        cfg_o <= dec_cfg_t'(bus_i.wdata[CFG_W-1:0]);
      end
    end
  end

  //----------------------------------------
  // Status count
  //----------------------------------------

  // Bit strobes since last control write, wraps at 16 bits
  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      bit_cnt <= '0;
    end else if (cfg_load_o) begin
      bit_cnt <= '0;
    end else if (bit_en_i) begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // Read mux, unmapped words read zero
  always_comb begin
    case (bus_i.addr)
      ADDR_CONTROL: rdata_o = {{(REG_W-CFG_W){1'b0}}, cfg_o};
      ADDR_STATUS:  rdata_o = {bit_cnt, {(REG_W-STAT_CNT_W-CFG_W){1'b0}}, cfg_o};
      default:      rdata_o = '0;
    endcase
  end

endmodule

/* pcm_decoder_pkg.sv */
//----------------------------------------
// PCM bit decoder shared definitions
// Widths, register map, mode codes and bus/config structs
//----------------------------------------

package pcm_decoder_pkg;

  // Bus and register widths
  localparam int ADDR_W     = 4;
  localparam int REG_W      = 32;
  localparam int STAT_CNT_W = 16;

  // Derandomizer history length and tap stages, stage 1 is newest
  localparam int DERAND_LEN   = 15;
  localparam int RNRZ15_TAP_A = 15;
  localparam int RNRZ15_TAP_B = 14;
  localparam int RNRZ11_TAP_A = 11;
  localparam int RNRZ11_TAP_B = 9;

  typedef logic [ADDR_W-1:0]     reg_addr_t;
  typedef logic [REG_W-1:0]      reg_data_t;
  typedef logic [STAT_CNT_W-1:0] stat_cnt_t;

  // Register map
  localparam reg_addr_t ADDR_CONTROL = 4'h0;
  localparam reg_addr_t ADDR_STATUS  = 4'h1;

  // Line codes
  typedef enum logic [1:0] {
    NRZ_L = 2'd0,
    NRZ_M = 2'd1,
    NRZ_S = 2'd2
  } code_mode_e;

  typedef enum logic [1:0] {
    DERAND_OFF    = 2'd0,
    DERAND_RNRZ15 = 2'd1,
    DERAND_RNRZ11 = 2'd2
  } derand_mode_e;

  typedef struct packed {
    logic      wr;
    reg_addr_t addr;
    reg_data_t wdata;
  } reg_bus_req_t;

  // Field order matches control word bits 8 down to 0
  typedef struct packed {
    logic         clk_sel;
    logic         data_inv;
    logic         iq_swap;
    logic         demux_en;
    logic         biphase_en;
    derand_mode_e derand_mode;
    code_mode_e   code_mode;
  } dec_cfg_t;

  localparam int CFG_W = $bits(dec_cfg_t);

  typedef struct packed {
    logic i;
    logic q;
  } symb_pair_t;

endpackage
